// File: sim.f
+incdir+include
hw/ex_pkg.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_writeback.sv
hw/ex_stage.sv
bench/ex_stage_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := ex_stage_tb
RTL_TOP    := ex_stage
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/ex_stage_tb.sv
// Self-checking testbench for the execute stage that runs as top level around ex_stage
`timescale 1ns/100ps
`default_nettype none

`include "ex_config.svh"

module ex_stage_tb;

  import ex_pkg::*;

  localparam int          XLEN        = `EX_XLEN;
  localparam int          CLK_PERIOD  = 4;
  localparam logic [31:0] SEED        = 32'h92f0196c;
  localparam int          N_ALU       = 400;
  localparam int          N_BR        = 40;
  localparam int          N_MUL       = 50;
  localparam int          N_CSR       = 200;
  localparam int          N_LSU       = 200;
  localparam int          N_BP        = 200;
  localparam int          READY_WAIT  = 8;
  // Every transaction takes at most two cycles with reset cycles and margin on top
  localparam int          MAX_CYCLES  =
    2 * (N_ALU + 6 * N_BR + 4 * N_MUL + N_CSR + N_LSU + N_BP) + 100;
  localparam int          WATCHDOG_NS = MAX_CYCLES * CLK_PERIOD;

  logic      clk;
  logic      rst_n;
  alu_req_t  alu_req;
  mult_req_t mult_req;
  logic      regfile_alu_we;
  logic      regfile_we;
  logic      csr_access;
  logic      lsu_en;
  logic      branch_in_ex;
  logic      lsu_ready_ex;
  logic      lsu_err;
  logic      wb_ready;
  reg_addr_t regfile_alu_waddr;
  reg_addr_t regfile_waddr;
  xlen_t     csr_rdata;
  xlen_t     lsu_rdata;
  wb_port_t  fw_port;
  wb_port_t  wb_port;
  xlen_t     jump_target;
  logic      branch_decision;
  logic      mult_multicycle;
  logic      ex_ready;
  logic      ex_valid;

  // Reference model state
  logic      high_phase;
  logic      fw_known;
  xlen_t     exp_fw_data;
  logic      exp_cmp;
  logic      exp_mult_ready;
  logic      exp_ready;
  logic      exp_valid;
  logic      exp_wb_we;
  reg_addr_t exp_wb_addr;
  int        errors;
  int        txn_count;
  int        tests_done;

  ex_stage ex_stage_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .mult_req_i          (mult_req),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_we_i        (regfile_we),
    .csr_access_i        (csr_access),
    .lsu_en_i            (lsu_en),
    .branch_in_ex_i      (branch_in_ex),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .lsu_err_i           (lsu_err),
    .wb_ready_i          (wb_ready),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_waddr_i     (regfile_waddr),
    .csr_rdata_i         (csr_rdata),
    .lsu_rdata_i         (lsu_rdata),
    .fw_port_o           (fw_port),
    .wb_port_o           (wb_port),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic is_branch_op(input alu_op_e op);
    return op inside {ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU};
  endfunction

  // Arithmetic, logic, shift and set-less-than results
  function automatic xlen_t alu_expected(input alu_op_e op, input xlen_t a, input xlen_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      default:  return '0;
    endcase
  endfunction

  function automatic logic cmp_expected(input alu_op_e op, input xlen_t a, input xlen_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LTS: return $signed(a) < $signed(b);
      ALU_LTU: return a < b;
      ALU_GES: return $signed(a) >= $signed(b);
      default: return a >= b;
    endcase
  endfunction

  // Full 64-bit product of the extended operands
  function automatic xlen_t mult_expected(input mult_op_e op, input xlen_t a, input xlen_t b);
    logic [2*XLEN-1:0] a64;
    logic [2*XLEN-1:0] b64;
    logic [2*XLEN-1:0] prod;
    a64 = {{XLEN{1'b0}}, a};
    b64 = {{XLEN{1'b0}}, b};
    if (op == MULH || op == MULHSU) begin
      a64[2*XLEN-1:XLEN] = {XLEN{a[XLEN-1]}};
    end
    if (op == MULH) begin
      b64[2*XLEN-1:XLEN] = {XLEN{b[XLEN-1]}};
    end
    prod = a64 * b64;
    return (op == MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
  endfunction

  always_comb begin
    // Forward data priority is csr then mult then alu
    fw_known = 1'b1;
    if (csr_access) begin
      exp_fw_data = csr_rdata;
    end else if (mult_req.enable) begin
      exp_fw_data = mult_expected(mult_req.op, mult_req.a, mult_req.b);
      // High word not valid yet in the first cycle
      fw_known = (mult_req.op == MUL) || high_phase;
    end else if (alu_req.enable) begin
      exp_fw_data = alu_expected(alu_req.op, alu_req.a, alu_req.b);
      fw_known = !is_branch_op(alu_req.op);
    end else begin
      exp_fw_data = '0;
    end
    exp_cmp        = cmp_expected(alu_req.op, alu_req.a, alu_req.b);
    exp_mult_ready = !(mult_req.enable && mult_req.op != MUL && !high_phase);
    exp_ready      = (exp_mult_ready && lsu_ready_ex && wb_ready) || branch_in_ex;
    exp_valid      = (alu_req.enable || mult_req.enable || csr_access || lsu_en)
                     && exp_mult_ready && lsu_ready_ex && wb_ready;
  end

  // Expected EX/WB load register
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_wb_we <= 1'b0;
    end else if (exp_valid) begin
      exp_wb_we   <= regfile_we & ~lsu_err;
      exp_wb_addr <= regfile_waddr;
    end else if (wb_ready) begin
      exp_wb_we <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  task automatic report_error(input string msg);
    errors++;
    $display("error %0t ns: %s", $time, msg);
  endtask

  fw_data_check: assert property (@(posedge clk) disable iff (!rst_n)
      (!fw_known || (fw_port.data == exp_fw_data)))
    else report_error($sformatf("forward data %h, expected %h",
                                $sampled(fw_port.data), $sampled(exp_fw_data)));

  fw_dest_check: assert property (@(posedge clk) disable iff (!rst_n)
      ((fw_port.we == regfile_alu_we) && (fw_port.addr == regfile_alu_waddr)))
    else report_error("forward enable or address differs from the ALU destination");

  branch_check: assert property (@(posedge clk) disable iff (!rst_n)
      (!is_branch_op(alu_req.op) || (branch_decision == exp_cmp)))
    else report_error($sformatf("branch decision %b, expected %b",
                                $sampled(branch_decision), $sampled(exp_cmp)));

  jump_check: assert property (@(posedge clk) disable iff (!rst_n) (jump_target == alu_req.c))
    else report_error("jump target differs from operand c");

  multicycle_check: assert property (@(posedge clk) disable iff (!rst_n)
      (mult_multicycle == !exp_mult_ready))
    else report_error("multicycle flag wrong for the multiply step");

  ready_check: assert property (@(posedge clk) disable iff (!rst_n) (ex_ready == exp_ready))
    else report_error($sformatf("ex_ready %b, expected %b",
                                $sampled(ex_ready), $sampled(exp_ready)));

  valid_check: assert property (@(posedge clk) disable iff (!rst_n) (ex_valid == exp_valid))
    else report_error($sformatf("ex_valid %b, expected %b",
                                $sampled(ex_valid), $sampled(exp_valid)));

  wb_we_check: assert property (@(posedge clk) disable iff (!rst_n) (wb_port.we == exp_wb_we))
    else report_error($sformatf("load write enable %b, expected %b",
                                $sampled(wb_port.we), $sampled(exp_wb_we)));

  wb_addr_data_check: assert property (@(posedge clk) disable iff (!rst_n)
      ((!exp_wb_we || (wb_port.addr == exp_wb_addr)) && (wb_port.data == lsu_rdata)))
    else report_error("load port address or data wrong");

  //////////////////////////////////////////////////
  // Clock, reset and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog: the run did not finish within %0d ns and was stopped", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Idle request without back-pressure
  task automatic clear_inputs();
    alu_req           = '0;
    mult_req          = '0;
    regfile_alu_we    = 1'b0;
    regfile_we        = 1'b0;
    csr_access        = 1'b0;
    lsu_en            = 1'b0;
    branch_in_ex      = 1'b0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    wb_ready          = 1'b1;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
    csr_rdata         = '0;
    lsu_rdata         = '0;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Random word with one draw in four taken from the corner values
  function automatic xlen_t pick_operand();
    xlen_t corners [5];
    corners = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};
    if ($urandom_range(3, 0) == 0) begin
      return corners[$urandom_range(4, 0)];
    end
    return $urandom();
  endfunction

  task automatic randomize_alu(input int max_op);
    alu_req.op        = alu_op_e'($urandom_range(max_op, 0));
    alu_req.a         = pick_operand();
    alu_req.b         = pick_operand();
    alu_req.c         = $urandom();
    regfile_alu_we    = 1'($urandom_range(1, 0));
    regfile_alu_waddr = reg_addr_t'($urandom());
  endtask

  // Holds the inputs set on a falling edge until the stage is ready
  task automatic run_txn();
    int   waited;
    logic holds;
    logic ready_now;
    waited     = 0;
    ready_now  = 1'b0;
    high_phase = 1'b0;
    holds      = mult_req.enable && (mult_req.op != MUL);
    txn_count++;
    while (!ready_now && waited < READY_WAIT) begin
      #1;
      ready_now = ex_ready || !holds;
      @(negedge clk);
      waited++;
      // A high multiply presents its result from the second cycle on
      high_phase = holds;
    end
    if (!ready_now) begin
      errors++;
      $display("The stage did not accept a high multiply within %0d cycles", READY_WAIT);
    end
  endtask

  task automatic end_test(input int num, input string name);
    tests_done++;
    $display("test %0d %s finished, %0d errors so far", num, name, errors);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    errors     = 0;
    txn_count  = 0;
    tests_done = 0;
    high_phase = 1'b0;
    rst_n      = 1'b0;
    clear_inputs();
    apply_reset();

    // ALU alone with arithmetic to set-less-than operators
    for (int i = 0; i < N_ALU; i++) begin
      alu_req.enable = 1'b1;
      randomize_alu(int'(ALU_SLTU));
      run_txn();
    end
    end_test(1, "alu operators");

    // Branch compares with some equal operand pairs
    clear_inputs();
    branch_in_ex = 1'b1;
    for (int op = int'(ALU_EQ); op <= int'(ALU_GEU); op++) begin
      for (int i = 0; i < N_BR; i++) begin
        randomize_alu(0);
        alu_req.op = alu_op_e'(op);
        if (i % 4 == 0) begin
          alu_req.b = alu_req.a;
        end
        run_txn();
      end
    end
    end_test(2, "branch compares");

    // Each multiply variant where high words take two cycles
    clear_inputs();
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < N_MUL; i++) begin
        mult_req.enable = 1'b1;
        mult_req.op     = mult_op_e'(op);
        mult_req.a      = pick_operand();
        mult_req.b      = pick_operand();
        run_txn();
      end
    end
    end_test(3, "multiplier");

    // CSR data wins over every other source
    clear_inputs();
    csr_access = 1'b1;
    for (int i = 0; i < N_CSR; i++) begin
      randomize_alu(15);
      alu_req.enable  = 1'($urandom_range(1, 0));
      mult_req.enable = 1'($urandom_range(1, 0));
      mult_req.op     = mult_op_e'($urandom_range(3, 0));
      mult_req.a      = pick_operand();
      mult_req.b      = pick_operand();
      csr_rdata       = $urandom();
      run_txn();
    end
    end_test(4, "csr priority");

    // Loads with errors, idle cycles, stalls and one reset in the middle
    clear_inputs();
    for (int i = 0; i < N_LSU; i++) begin
      lsu_en        = ($urandom_range(3, 0) != 0);
      regfile_we    = 1'($urandom_range(1, 0));
      lsu_err       = ($urandom_range(3, 0) == 0);
      regfile_waddr = reg_addr_t'($urandom());
      lsu_rdata     = $urandom();
      wb_ready      = ($urandom_range(7, 0) != 0);
      run_txn();
      if (i == N_LSU / 2) begin
        apply_reset();
      end
    end
    end_test(5, "load port");

    // Back-pressure from writeback and LSU that branches bypass
    clear_inputs();
    for (int i = 0; i < N_BP; i++) begin
      randomize_alu(int'(ALU_SLTU));
      alu_req.enable = 1'($urandom_range(1, 0));
      lsu_en         = 1'($urandom_range(1, 0));
      csr_access     = ($urandom_range(3, 0) == 0);
      regfile_we     = 1'($urandom_range(1, 0));
      regfile_waddr  = reg_addr_t'($urandom());
      lsu_rdata      = $urandom();
      wb_ready       = 1'($urandom_range(1, 0));
      lsu_ready_ex   = 1'($urandom_range(1, 0));
      branch_in_ex   = 1'($urandom_range(1, 0));
      run_txn();
    end
    end_test(6, "back-pressure");

    $display("Summary: %0d tests, %0d transactions, %0d errors", tests_done, txn_count, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/ex_stage.sv
// Top of the execute stage, connecting decode, ALU, multiplier and writeback
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::alu_req_t  alu_req_i,
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              regfile_alu_we_i,
  input  logic              regfile_we_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  logic              branch_in_ex_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  ex_pkg::xlen_t     csr_rdata_i,
  input  ex_pkg::xlen_t     lsu_rdata_i,
  output ex_pkg::wb_port_t  fw_port_o,
  output ex_pkg::wb_port_t  wb_port_o,
  output ex_pkg::xlen_t     jump_target_o,
  output logic              branch_decision_o,
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  alu_ctrl_t alu_ctrl;
  xlen_t     alu_result;
  logic      alu_cmp;
  xlen_t     mult_result;
  logic      mult_ready;
  wb_port_t  alu_dst;
  wb_port_t  lsu_dst;

  // Destinations only, data is filled in by the writeback mux
  assign alu_dst = '{we: regfile_alu_we_i, addr: regfile_alu_waddr_i, data: '0};
  assign lsu_dst = '{we: regfile_we_i, addr: regfile_waddr_i, data: '0};

  // Branch outputs to fetch
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.c;
  assign mult_multicycle_o = ~mult_ready;

  //////////////////////////////////////////////////
  // Decode and ALU
  //////////////////////////////////////////////////

  ex_decode decode_i (
    .alu_op_i   (alu_req_i.op),
    .alu_ctrl_o (alu_ctrl)
  );

  ex_alu alu_i (
    .operand_a_i  (alu_req_i.a),
    .operand_b_i  (alu_req_i.b),
    .alu_ctrl_i   (alu_ctrl),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  ex_mult mult_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .mult_req_i (mult_req_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  //////////////////////////////////////////////////
  // Write ports and handshake
  //////////////////////////////////////////////////

  ex_writeback writeback_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .alu_en_i       (alu_req_i.enable),
    .mult_en_i      (mult_req_i.enable),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .csr_rdata_i    (csr_rdata_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .alu_dst_i      (alu_dst),
    .lsu_dst_i      (lsu_dst),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .lsu_err_i      (lsu_err_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .fw_port_o      (fw_port_o),
    .wb_port_o      (wb_port_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

endmodule

`default_nettype wire

// File: hw/ex_writeback.sv
// ALU write-port mux, EX/WB load-port register and stall handshake of the execute stage
`timescale 1ns/100ps
`default_nettype none

module ex_writeback (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alu_en_i,
  input  logic             mult_en_i,
  input  logic             csr_access_i,
  input  logic             lsu_en_i,
  input  ex_pkg::xlen_t    alu_result_i,
  input  ex_pkg::xlen_t    mult_result_i,
  input  ex_pkg::xlen_t    csr_rdata_i,
  input  ex_pkg::xlen_t    lsu_rdata_i,
  input  ex_pkg::wb_port_t alu_dst_i,
  input  ex_pkg::wb_port_t lsu_dst_i,
  input  logic             mult_ready_i,
  input  logic             lsu_ready_ex_i,
  input  logic             lsu_err_i,
  input  logic             wb_ready_i,
  input  logic             branch_in_ex_i,
  output ex_pkg::wb_port_t fw_port_o,
  output ex_pkg::wb_port_t wb_port_o,
  output logic             ex_ready_o,
  output logic             ex_valid_o
);

  import ex_pkg::*;

  logic      no_stall;
  logic      any_en;
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;

  //////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////

  always_comb begin
    fw_port_o.we   = alu_dst_i.we;
    fw_port_o.addr = alu_dst_i.addr;
    // Priority csr, mult, alu
    if (csr_access_i) begin
      fw_port_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.data = mult_result_i;
    end else if (alu_en_i) begin
      fw_port_o.data = alu_result_i;
    end else begin
      fw_port_o.data = '0;
    end
  end

  //////////////////////////////////////////////////
  // Ready and valid
  //////////////////////////////////////////////////

  assign no_stall = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en   = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches retire in EX, so they never wait on WB
  assign ex_ready_o = no_stall | branch_in_ex_i;
  // Independent of ex_ready_o
  assign ex_valid_o = any_en & no_stall;

  //////////////////////////////////////////////////
  // EX/WB load register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      // Faulting access never writes
      lsu_we_q <= lsu_dst_i.we & ~lsu_err_i;
    end else if (wb_ready_i) begin
      // Bubble moves into WB
      lsu_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o) begin
      lsu_waddr_q <= lsu_dst_i.addr;
    end
  end

  // Load data arrives straight from the LSU in the WB cycle
  assign wb_port_o.we   = lsu_we_q;
  assign wb_port_o.addr = lsu_waddr_q;
  assign wb_port_o.data = lsu_rdata_i;

endmodule

`default_nettype wire

// File: hw/ex_mult.sv
// Integer multiplier, single-cycle low word and two-cycle high word
`timescale 1ns/100ps
`default_nettype none

module ex_mult (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              ex_ready_i,
  output ex_pkg::xlen_t     result_o,
  output logic              ready_o
);

  import ex_pkg::*;

  localparam int XLEN = $bits(xlen_t);
  localparam int HALF = XLEN / 2;

  logic                      a_sign;
  logic                      b_sign;
  logic [XLEN:0]             a_ext;
  logic [XLEN:0]             b_ext;
  logic signed [HALF:0]      a_hi;
  logic signed [HALF:0]      b_hi;
  logic [HALF-1:0]           a_lo;
  logic [HALF-1:0]           b_lo;
  logic [XLEN-1:0]           prod_ll;
  logic signed [2*HALF+1:0]  cross_ab;
  logic signed [2*HALF+1:0]  cross_ba;
  logic signed [2*HALF+3:0]  mid_sum;
  logic signed [2*HALF+1:0]  prod_hh;
  logic signed [2*HALF+3:0]  mid_q;
  logic signed [2*HALF+1:0]  hh_q;
  logic signed [2*HALF+3:0]  high_full;
  xlen_t                     low_word;
  logic                      is_high;
  logic                      step_q;

  //////////////////////////////////////////////////
  // Low word, one cycle
  //////////////////////////////////////////////////

  assign low_word = mult_req_i.a * mult_req_i.b;

  //////////////////////////////////////////////////
  // High word partial products
  //////////////////////////////////////////////////

  // Sign extension by operator
  assign a_sign = (mult_req_i.op == MULH || mult_req_i.op == MULHSU) & mult_req_i.a[XLEN-1];
  assign b_sign = (mult_req_i.op == MULH) & mult_req_i.b[XLEN-1];
  assign a_ext  = {a_sign, mult_req_i.a};
  assign b_ext  = {b_sign, mult_req_i.b};

  // Upper halves signed, lower halves unsigned
  assign a_hi = a_ext[XLEN:HALF];
  assign b_hi = b_ext[XLEN:HALF];
  assign a_lo = a_ext[HALF-1:0];
  assign b_lo = b_ext[HALF-1:0];

  assign prod_ll  = a_lo * b_lo;
  assign cross_ab = a_hi * $signed({1'b0, b_lo});
  assign cross_ba = $signed({1'b0, a_lo}) * b_hi;
  assign prod_hh  = a_hi * b_hi;

  // Middle column with the carry out of the low product
  assign mid_sum = cross_ab + cross_ba + $signed({1'b0, prod_ll[XLEN-1:HALF]});

  //////////////////////////////////////////////////
  // Step state
  //////////////////////////////////////////////////

  assign is_high = mult_req_i.enable & (mult_req_i.op != MUL);

  // Busy in the first cycle of a high multiply only
  assign ready_o = ~(is_high & ~step_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q <= 1'b0;
    end else if (is_high && !step_q) begin
      step_q <= 1'b1;
    end else if (step_q && ex_ready_i) begin
      // Result taken, back to idle
      step_q <= 1'b0;
    end
  end

  // Partial sums captured in the first cycle
  always_ff @(posedge clk) begin
    if (is_high && !step_q) begin
      mid_q <= mid_sum;
      hh_q  <= prod_hh;
    end
  end

  // Final carry-propagating add in the second cycle
  assign high_full = hh_q + (mid_q >>> HALF);

  assign result_o = (mult_req_i.op == MUL) ? low_word : high_full[XLEN-1:0];

endmodule

`default_nettype wire

// File: hw/ex_alu.sv
// Integer ALU of the execute stage, driven by the decoded controls from ex_decode
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
  input  ex_pkg::xlen_t     operand_a_i,
  input  ex_pkg::xlen_t     operand_b_i,
  input  ex_pkg::alu_ctrl_t alu_ctrl_i,
  output ex_pkg::xlen_t     result_o,
  output logic              cmp_result_o
);

  import ex_pkg::*;

  localparam int XLEN = $bits(xlen_t);

  // Mirror a word end to end
  function automatic xlen_t bit_reverse(input xlen_t value);
    xlen_t rev;
    for (int i = 0; i < XLEN; i++) begin
      rev[i] = value[XLEN-1-i];
    end
    return rev;
  endfunction

  logic [XLEN:0]        add_a;
  logic [XLEN:0]        add_b;
  logic [XLEN:0]        add_sum;
  logic                 is_equal;
  logic                 is_less;
  logic                 cmp_raw;
  xlen_t                shift_in;
  logic signed [XLEN:0] shift_ext;
  logic signed [XLEN:0] shift_out;
  xlen_t                shift_result;
  xlen_t                logic_result;

  //////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////

  // One extra bit so the top bit of a difference is the less-than flag
  assign add_a   = {alu_ctrl_i.cmp_signed & operand_a_i[XLEN-1], operand_a_i};
  assign add_b   = {alu_ctrl_i.cmp_signed & operand_b_i[XLEN-1], operand_b_i};
  assign add_sum = add_a + (alu_ctrl_i.sub ? ~add_b : add_b) + {{XLEN{1'b0}}, alu_ctrl_i.sub};

  // Compare flags read off the difference
  assign is_equal = ~|add_sum[XLEN-1:0];
  assign is_less  = add_sum[XLEN];

  always_comb begin
    unique case (alu_ctrl_i.cmp_kind)
      CMP_EQ:  cmp_raw = is_equal;
      CMP_LT:  cmp_raw = is_less;
      CMP_GE:  cmp_raw = ~is_less;
      default: cmp_raw = 1'b0;
    endcase
  end

  assign cmp_result_o = cmp_raw ^ alu_ctrl_i.cmp_invert;

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  // Left shift = reverse, shift right, reverse back
  assign shift_in  = alu_ctrl_i.shift_right ? operand_a_i : bit_reverse(operand_a_i);
  assign shift_ext = {alu_ctrl_i.shift_arith & shift_in[XLEN-1], shift_in};
  assign shift_out = shift_ext >>> operand_b_i[$clog2(XLEN)-1:0];

  assign shift_result = alu_ctrl_i.shift_right ? shift_out[XLEN-1:0]
                                               : bit_reverse(shift_out[XLEN-1:0]);

  //////////////////////////////////////////////////
  // Logic unit and result mux
  //////////////////////////////////////////////////

  always_comb begin
    unique case (alu_ctrl_i.logic_fn)
      LOGIC_OR:  logic_result = operand_a_i | operand_b_i;
      LOGIC_XOR: logic_result = operand_a_i ^ operand_b_i;
      default:   logic_result = operand_a_i & operand_b_i;
    endcase
  end

  always_comb begin
    unique case (alu_ctrl_i.res_sel)
      RES_LOGIC: result_o = logic_result;
      RES_SHIFT: result_o = shift_result;
      // Set-less-than, compare bit zero-extended
      RES_CMP:   result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
      default:   result_o = add_sum[XLEN-1:0];
    endcase
  end

endmodule

`default_nettype wire

// File: hw/ex_decode.sv
// Maps the issued ALU operator to the internal adder, shifter, compare and mux controls
`timescale 1ns/100ps
`default_nettype none

module ex_decode (
  input  ex_pkg::alu_op_e   alu_op_i,
  output ex_pkg::alu_ctrl_t alu_ctrl_o
);

  import ex_pkg::*;

  //////////////////////////////////////////////////
  // Operator table
  //////////////////////////////////////////////////

  always_comb begin
    // Plain add unless an operator says otherwise
    alu_ctrl_o             = '0;
    alu_ctrl_o.cmp_kind    = CMP_EQ;
    alu_ctrl_o.res_sel     = RES_ADDER;
    alu_ctrl_o.logic_fn    = LOGIC_AND;

    unique case (alu_op_i)
      ALU_ADD: begin
        alu_ctrl_o.res_sel = RES_ADDER;
      end
      ALU_SUB: begin
        alu_ctrl_o.sub = 1'b1;
      end

      // Bitwise group
      ALU_AND: begin
        alu_ctrl_o.res_sel  = RES_LOGIC;
        alu_ctrl_o.logic_fn = LOGIC_AND;
      end
      ALU_OR: begin
        alu_ctrl_o.res_sel  = RES_LOGIC;
        alu_ctrl_o.logic_fn = LOGIC_OR;
      end
      ALU_XOR: begin
        alu_ctrl_o.res_sel  = RES_LOGIC;
        alu_ctrl_o.logic_fn = LOGIC_XOR;
      end

      // Shifts, left goes through the reversed right shifter
      ALU_SLL: begin
        alu_ctrl_o.res_sel = RES_SHIFT;
      end
      ALU_SRL: begin
        alu_ctrl_o.res_sel     = RES_SHIFT;
        alu_ctrl_o.shift_right = 1'b1;
      end
      ALU_SRA: begin
        alu_ctrl_o.res_sel     = RES_SHIFT;
        alu_ctrl_o.shift_right = 1'b1;
        alu_ctrl_o.shift_arith = 1'b1;
      end

      // Set-less-than writes the compare bit
      ALU_SLT, ALU_SLTU: begin
        alu_ctrl_o.res_sel    = RES_CMP;
        alu_ctrl_o.sub        = 1'b1;
        alu_ctrl_o.cmp_kind   = CMP_LT;
        alu_ctrl_o.cmp_signed = (alu_op_i == ALU_SLT);
      end

      // Branch compares, all on the subtracting adder
      ALU_EQ, ALU_NE: begin
        alu_ctrl_o.sub        = 1'b1;
        alu_ctrl_o.cmp_kind   = CMP_EQ;
        alu_ctrl_o.cmp_invert = (alu_op_i == ALU_NE);
      end
      ALU_LTS, ALU_LTU: begin
        alu_ctrl_o.sub        = 1'b1;
        alu_ctrl_o.cmp_kind   = CMP_LT;
        alu_ctrl_o.cmp_signed = (alu_op_i == ALU_LTS);
      end
      ALU_GES, ALU_GEU: begin
        alu_ctrl_o.sub        = 1'b1;
        alu_ctrl_o.cmp_kind   = CMP_GE;
        alu_ctrl_o.cmp_signed = (alu_op_i == ALU_GES);
      end
      default: begin
        alu_ctrl_o.res_sel = RES_ADDER;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/ex_pkg.sv
// Shared types of the execute stage, imported by every module of the stage
`default_nettype none

`include "ex_config.svh"

package ex_pkg;

  //////////////////////////////////////////////////
  // Basic words
  //////////////////////////////////////////////////

  typedef logic [`EX_XLEN-1:0]       xlen_t;
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Operator codes from decode
  //////////////////////////////////////////////////

  // Arithmetic, logic, shift, set-less-than and branch compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU
  } alu_op_e;

  // Low word and the three high-word variants
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MUL, MULH, MULHU, MULHSU
  } mult_op_e;

  //////////////////////////////////////////////////
  // Decoded ALU controls
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {CMP_EQ, CMP_LT, CMP_GE} cmp_kind_e;
  typedef enum logic [1:0] {RES_ADDER, RES_LOGIC, RES_SHIFT, RES_CMP} res_sel_e;
  typedef enum logic [1:0] {LOGIC_AND, LOGIC_OR, LOGIC_XOR} logic_fn_e;

  typedef struct packed {
    logic      sub;
    logic      cmp_signed;
    cmp_kind_e cmp_kind;
    // Flips the compare outcome, used for not-equal
    logic      cmp_invert;
    logic      shift_right;
    logic      shift_arith;
    res_sel_e  res_sel;
    logic_fn_e logic_fn;
  } alu_ctrl_t;

  //////////////////////////////////////////////////
  // Requests and write ports
  //////////////////////////////////////////////////

  // Operand c carries the jump target
  typedef struct packed {
    logic    enable;
    alu_op_e op;
    xlen_t   a;
    xlen_t   b;
    xlen_t   c;
  } alu_req_t;

  typedef struct packed {
    logic     enable;
    mult_op_e op;
    xlen_t    a;
    xlen_t    b;
  } mult_req_t;

  // Register file write port, forwarding or load
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    xlen_t     data;
  } wb_port_t;

endpackage

`default_nettype wire

// File: include/ex_config.svh
// Width settings for the execute stage, included by the package and the testbench
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

//////////////////////////////////////////////////
// Data path
//////////////////////////////////////////////////

// One data word
`define EX_XLEN 32

// Register file address, 64 entries
`define EX_REG_ADDR_W 6

//////////////////////////////////////////////////
// Operator codes
//////////////////////////////////////////////////

// ALU operator field, 16 codes
`define EX_ALU_OP_W 4

// Multiplier operator field
`define EX_MULT_OP_W 2

`endif
